// ==== rtl/softex_ctrl_cfg_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface softex_ctrl_cfg_if;

    logic                         start;    // One cycle, follows a trigger write
    logic [31:0]                  in_addr;
    logic [31:0]                  out_addr;
    softex_ctrl_pkg::beats_t      beats;
    softex_ctrl_pkg::softex_cmd_t cmd;
    logic                         busy;
    logic                         done;     // One cycle, in FINISHED

    modport regs (
        output start,
        output in_addr,
        output out_addr,
        output beats,
        output cmd,
        input  busy,
        input  done
    );

    modport seq (
        input  start,
        input  cmd,
        output busy,
        output done
    );

endinterface

`default_nettype wire

// ==== rtl/softex_ctrl_defs.svh ====
`ifndef SOFTEX_CTRL_DEFS_SVH
`define SOFTEX_CTRL_DEFS_SVH

// Datapath geometry
`define SOFTEX_NUM_LANES        4
`define SOFTEX_DATA_WIDTH       128

// Register indices, as seen on reg_addr_i
`define SOFTEX_REG_IN_ADDR      3'd0
`define SOFTEX_REG_OUT_ADDR     3'd1
`define SOFTEX_REG_TOT_LEN      3'd2
`define SOFTEX_REG_COMMANDS     3'd3
`define SOFTEX_REG_TRIGGER      3'd4

// Bit positions inside the commands register
`define SOFTEX_CMD_ACC_ONLY     0
`define SOFTEX_CMD_DIV_ONLY     1
`define SOFTEX_CMD_LAST         2
`define SOFTEX_CMD_ACQUIRE_SLOT 3
`define SOFTEX_CMD_NO_OP        4

`endif

// ==== rtl/softex_ctrl_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "softex_ctrl_defs.svh"

module softex_ctrl_fsm (
    input  wire logic                         clk_i,
    input  wire logic                         rst_ni,
    input  wire logic                         in_done_i,
    input  wire logic                         out_done_i,
    input  wire logic                         slot_valid_i,
    input  wire logic [`SOFTEX_NUM_LANES-1:0] lane_busy_i,
    input  wire logic [`SOFTEX_NUM_LANES-1:0] lane_acc_done_i,
    input  wire logic [`SOFTEX_NUM_LANES-1:0] lane_inv_done_i,
    output logic                              in_start_o,
    output logic                              out_start_o,
    output logic                              acc_finished_o,
    output logic                              dividing_o,
    output logic                              disable_max_o,
    output logic                              clear_regs_o,
    output logic                              load_max_o,
    output logic                              load_denom_o,
    output logic                              load_recip_o,
    output logic                              slot_update_o,
    output logic                              slot_free_o,
    softex_ctrl_cfg_if.seq                    cfg
);

    softex_ctrl_pkg::softex_state_t state_q;
    softex_ctrl_pkg::softex_state_t state_d;

    logic all_idle;
    logic all_acc_done;
    logic all_inv_done;
    logic partial;
    logic launch;
    logic busy;
    logic done;

    assign all_idle     = ~(|lane_busy_i);
    assign all_acc_done = &lane_acc_done_i;
    assign all_inv_done = &lane_inv_done_i;

    assign partial = cfg.cmd.acc_only | cfg.cmd.div_only;

    // Streams start either straight from a trigger or once the slot turns valid
    assign launch = ((state_q == softex_ctrl_pkg::IDLE) & cfg.start & ~cfg.cmd.no_op
                     & (slot_valid_i | ~partial))
                  | ((state_q == softex_ctrl_pkg::WAIT_SLOT_VALID) & slot_valid_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= softex_ctrl_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d        = state_q;
        in_start_o     = 1'b0;
        out_start_o    = 1'b0;
        acc_finished_o = 1'b0;
        dividing_o     = 1'b0;
        disable_max_o  = 1'b0;
        clear_regs_o   = 1'b0;
        load_max_o     = 1'b0;
        load_denom_o   = 1'b0;
        load_recip_o   = 1'b0;
        slot_update_o  = 1'b0;
        slot_free_o    = 1'b0;
        busy           = 1'b1;
        done           = 1'b0;

        case (state_q)
            softex_ctrl_pkg::IDLE: begin
                busy = 1'b0;
                if (cfg.start) begin
                    if (cfg.cmd.no_op) begin
                        state_d = softex_ctrl_pkg::FINISHED;
                    end else if (partial && !slot_valid_i) begin
                        state_d = softex_ctrl_pkg::WAIT_SLOT_VALID;
                    end
                end
            end

            softex_ctrl_pkg::WAIT_SLOT_VALID: ; // Left through the launch below

            softex_ctrl_pkg::ACCUMULATION: begin
                if (in_done_i) begin
                    state_d = softex_ctrl_pkg::WAIT_DATAPATH_EMPTY;
                end
            end

            softex_ctrl_pkg::WAIT_DATAPATH_EMPTY: begin
                if (all_idle) begin
                    acc_finished_o = 1'b1;
                    state_d        = softex_ctrl_pkg::WAIT_ACCUMULATION;
                end
            end

            softex_ctrl_pkg::WAIT_ACCUMULATION: begin
                acc_finished_o = 1'b1;
                disable_max_o  = 1'b1;
                if (all_acc_done) begin
                    if (cfg.cmd.acc_only && !cfg.cmd.last) begin
                        state_d = softex_ctrl_pkg::FINISHED;
                    end else begin
                        // A full job rereads the input while writing the result
                        if (!cfg.cmd.acc_only) begin
                            acc_finished_o = 1'b0;
                            in_start_o     = 1'b1;
                            out_start_o    = 1'b1;
                        end
                        state_d = softex_ctrl_pkg::WAIT_INVERSION;
                    end
                end
            end

            softex_ctrl_pkg::WAIT_INVERSION: begin
                dividing_o    = 1'b1;
                disable_max_o = 1'b1;
                if (all_inv_done) begin
                    state_d = cfg.cmd.acc_only ? softex_ctrl_pkg::FINISHED
                                               : softex_ctrl_pkg::DIVIDING;
                end
            end

            softex_ctrl_pkg::DIVIDING: begin
                dividing_o    = 1'b1;
                disable_max_o = 1'b1;
                if (out_done_i) begin
                    state_d = softex_ctrl_pkg::FINISHED;
                end
            end

            softex_ctrl_pkg::FINISHED: begin
                busy         = 1'b0;
                done         = 1'b1;
                clear_regs_o = 1'b1;
                // The slot keeps the running max and denominator between passes
                slot_update_o = cfg.cmd.acc_only | (cfg.cmd.div_only & cfg.cmd.last);
                slot_free_o   = cfg.cmd.div_only & cfg.cmd.last;
                state_d       = softex_ctrl_pkg::IDLE;
            end

            default: state_d = softex_ctrl_pkg::IDLE;
        endcase

        if (launch) begin
            in_start_o = 1'b1;
            if (cfg.cmd.div_only) begin
                out_start_o = 1'b1;
            end
            if (partial && !cfg.cmd.acquire_slot) begin
                load_max_o   = 1'b1;
                load_denom_o = cfg.cmd.acc_only;
                load_recip_o = cfg.cmd.div_only;
            end
            state_d = cfg.cmd.div_only ? softex_ctrl_pkg::DIVIDING
                                       : softex_ctrl_pkg::ACCUMULATION;
        end
    end

    assign cfg.busy = busy;
    assign cfg.done = done;

endmodule

`default_nettype wire

// ==== rtl/softex_ctrl_pkg.sv ====
`default_nettype none

package softex_ctrl_pkg;

    // Sequencer states of the controller
    typedef enum logic [2:0] {
        IDLE,
        WAIT_SLOT_VALID,
        ACCUMULATION,
        WAIT_DATAPATH_EMPTY,
        WAIT_ACCUMULATION,
        WAIT_INVERSION,
        DIVIDING,
        FINISHED
    } softex_state_t;

    // Decoded commands register, slot address on top
    typedef struct packed {
        logic [15:0] slot_addr;
        logic        no_op;        // Only raise the done event
        logic        acquire_slot; // First partial pass, nothing to load from the slot
        logic        last;         // Final partial pass of an operation
        logic        div_only;     // Normalisation only, max and reciprocal come from the slot
        logic        acc_only;     // Stop once the denominator is known
    } softex_cmd_t;

    // Number of bus beats per stream
    typedef logic [31:0] beats_t;

endpackage

`default_nettype wire

// ==== rtl/softex_ctrl_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "softex_ctrl_defs.svh"

module softex_ctrl_regfile (
    input  wire logic        clk_i,
    input  wire logic        rst_ni,
    input  wire logic        reg_req_i,
    input  wire logic [2:0]  reg_addr_i,
    input  wire logic [31:0] reg_wdata_i,
    output logic             done_evt_o,
    softex_ctrl_cfg_if.regs  cfg
);

    localparam int unsigned BEAT_BYTES = `SOFTEX_DATA_WIDTH / 8;
    localparam int unsigned OFFS_W     = $clog2(BEAT_BYTES);

    logic [31:0]                  in_addr_q;
    logic [31:0]                  out_addr_q;
    logic [31:0]                  tot_len_q;
    softex_ctrl_pkg::softex_cmd_t cmd_q;
    softex_ctrl_pkg::beats_t      beats_q;
    softex_ctrl_pkg::beats_t      beats_d;
    logic                         partial_beat;
    logic                         wr_en;
    logic                         trigger;
    logic                         start_q;
    logic                         done_evt_q;

    // A start still waiting for the FSM counts as busy too
    assign wr_en   = reg_req_i & ~cfg.busy & ~start_q;
    assign trigger = wr_en & (reg_addr_i == `SOFTEX_REG_TRIGGER);

    // A short last beat still costs a full bus transfer
    assign partial_beat = |tot_len_q[OFFS_W-1:0];
    assign beats_d      = (tot_len_q >> OFFS_W) + softex_ctrl_pkg::beats_t'(partial_beat);

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            case (reg_addr_i)
                `SOFTEX_REG_IN_ADDR:  in_addr_q  <= reg_wdata_i;
                `SOFTEX_REG_OUT_ADDR: out_addr_q <= reg_wdata_i;
                `SOFTEX_REG_TOT_LEN:  tot_len_q  <= reg_wdata_i;
                default: ;
            endcase
        end
        if (trigger) begin
            beats_q <= beats_d; // Frozen until the next trigger
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cmd_q      <= '0;
            start_q    <= 1'b0;
            done_evt_q <= 1'b0;
        end else begin
            start_q    <= trigger;
            done_evt_q <= cfg.done;
            if (wr_en && (reg_addr_i == `SOFTEX_REG_COMMANDS)) begin
                cmd_q.acc_only     <= reg_wdata_i[`SOFTEX_CMD_ACC_ONLY];
                cmd_q.div_only     <= reg_wdata_i[`SOFTEX_CMD_DIV_ONLY];
                cmd_q.last         <= reg_wdata_i[`SOFTEX_CMD_LAST];
                cmd_q.acquire_slot <= reg_wdata_i[`SOFTEX_CMD_ACQUIRE_SLOT];
                cmd_q.no_op        <= reg_wdata_i[`SOFTEX_CMD_NO_OP];
                cmd_q.slot_addr    <= reg_wdata_i[31:16];
            end
        end
    end

    assign cfg.start    = start_q;
    assign cfg.in_addr  = in_addr_q;
    assign cfg.out_addr = out_addr_q;
    assign cfg.beats    = beats_q;
    assign cfg.cmd      = cmd_q;

    assign done_evt_o = done_evt_q;

endmodule

`default_nettype wire

// ==== rtl/softex_ctrl_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "softex_ctrl_defs.svh"

module softex_ctrl_top (
    input  wire logic                         clk_i,
    input  wire logic                         rst_ni,
    input  wire logic                         reg_req_i,
    input  wire logic [2:0]                   reg_addr_i,
    input  wire logic [31:0]                  reg_wdata_i,
    input  wire logic                         in_done_i,
    input  wire logic                         out_done_i,
    input  wire logic                         slot_valid_i,
    input  wire logic [`SOFTEX_NUM_LANES-1:0] lane_busy_i,
    input  wire logic [`SOFTEX_NUM_LANES-1:0] lane_acc_done_i,
    input  wire logic [`SOFTEX_NUM_LANES-1:0] lane_inv_done_i,
    output logic                              done_evt_o,
    output logic                              busy_o,
    output logic [31:0]                       in_addr_o,
    output logic [31:0]                       out_addr_o,
    output softex_ctrl_pkg::beats_t           beats_o,
    output logic [15:0]                       slot_addr_o,
    output logic                              in_start_o,
    output logic                              out_start_o,
    output logic                              acc_finished_o,
    output logic                              dividing_o,
    output logic                              disable_max_o,
    output logic                              clear_regs_o,
    output logic                              load_max_o,
    output logic                              load_denom_o,
    output logic                              load_recip_o,
    output logic                              slot_update_o,
    output logic                              slot_free_o
);

    softex_ctrl_cfg_if cfg ();

    softex_ctrl_regfile i_regfile (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .reg_req_i   (reg_req_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .done_evt_o  (done_evt_o),
        .cfg         (cfg)
    );

    softex_ctrl_fsm i_fsm (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .in_done_i       (in_done_i),
        .out_done_i      (out_done_i),
        .slot_valid_i    (slot_valid_i),
        .lane_busy_i     (lane_busy_i),
        .lane_acc_done_i (lane_acc_done_i),
        .lane_inv_done_i (lane_inv_done_i),
        .in_start_o      (in_start_o),
        .out_start_o     (out_start_o),
        .acc_finished_o  (acc_finished_o),
        .dividing_o      (dividing_o),
        .disable_max_o   (disable_max_o),
        .clear_regs_o    (clear_regs_o),
        .load_max_o      (load_max_o),
        .load_denom_o    (load_denom_o),
        .load_recip_o    (load_recip_o),
        .slot_update_o   (slot_update_o),
        .slot_free_o     (slot_free_o),
        .cfg             (cfg)
    );

    // Job configuration for the streamers and the slot store
    assign busy_o      = cfg.busy;
    assign in_addr_o   = cfg.in_addr;
    assign out_addr_o  = cfg.out_addr;
    assign beats_o     = cfg.beats;
    assign slot_addr_o = cfg.cmd.slot_addr;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module softex_ctrl_tb -f softex_ctrl.f \
    -o softex_ctrl_sim > sim.log 2>&1 \
    && ./obj_dir/softex_ctrl_sim >> sim.log 2>&1 \
    || echo "Checks failed" >> sim.log
cat sim.log
grep -q "Checks failed" sim.log && exit 1
exit 0

// ==== softex_ctrl.f ====
+incdir+rtl
rtl/softex_ctrl_pkg.sv
rtl/softex_ctrl_cfg_if.sv
rtl/softex_ctrl_regfile.sv
rtl/softex_ctrl_fsm.sv
rtl/softex_ctrl_top.sv
testbench/softex_ctrl_props.sv
testbench/softex_ctrl_tb.sv

// ==== testbench/softex_ctrl_golden.txt ====
// cmd len in_addr out_addr slot_dly busy_len_write write_len
// exp_beats exp_in_starts exp_out_starts exp_slot_update exp_slot_free
// Full softmax, length a multiple of 16
00000000 00000100 10000000 20000000 0 0 1 00000010 2 1 0 0
// Full softmax, partial last beat
00000000 00000105 10000400 20000400 0 0 1 00000011 2 1 0 0
// Accumulate only, first pass that acquires the slot
00030009 00000040 10000800 20000800 0 0 1 00000004 1 0 1 0
// Accumulate only, slot valid late
00030001 00000041 10000900 20000900 5 0 1 00000005 1 0 1 0
// Accumulate only, last pass
00030005 00000030 10000a00 20000a00 0 0 1 00000003 1 0 1 0
// Divide only, last pass, slot valid late
00030006 00000030 10000b00 20000b00 9 0 1 00000003 1 1 1 1
// No operation
00000010 00000080 10000c00 20000c00 0 0 1 00000008 0 0 0 0
// Full softmax with a length write while busy
00000000 000001f0 10000d00 20000d00 0 00007ff0 1 0000001f 2 1 0 0
// Full softmax reusing the stored length
00000000 000001f0 10000e00 20000e00 0 0 0 0000001f 2 1 0 0

// ==== testbench/softex_ctrl_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module softex_ctrl_props (
    input wire logic clk_i,
    input wire logic rst_ni,
    input wire logic busy_i,
    input wire logic in_start_i,
    input wire logic disable_max_i,
    input wire logic slot_valid_i,
    input wire logic load_max_i,
    input wire logic load_denom_i,
    input wire logic load_recip_i,
    input wire logic done_evt_i
);

    int unsigned failures = 0;
    logic        load_any;

    assign load_any = load_max_i | load_denom_i | load_recip_i;

    // Starts come from IDLE, the slot turning valid, or the handoff to division
    a_start_allowed: assert property (@(posedge clk_i) disable iff (!rst_ni)
        in_start_i |-> (!busy_i || disable_max_i || $rose(slot_valid_i)))
        else begin
            failures++;
            $error("in_start_o outside idle, slot launch or handoff");
        end

    a_load_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        load_any |=> !load_any)
        else begin
            failures++;
            $error("load strobe held for more than one cycle");
        end

    a_done_not_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(done_evt_i && busy_i))
        else begin
            failures++;
            $error("done_evt_o while busy_o is high");
        end

endmodule

bind softex_ctrl_top softex_ctrl_props i_props (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .busy_i        (busy_o),
    .in_start_i    (in_start_o),
    .disable_max_i (disable_max_o),
    .slot_valid_i  (slot_valid_i),
    .load_max_i    (load_max_o),
    .load_denom_i  (load_denom_o),
    .load_recip_i  (load_recip_o),
    .done_evt_i    (done_evt_o)
);

`default_nettype wire

// ==== testbench/softex_ctrl_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "softex_ctrl_defs.svh"

module softex_ctrl_tb;

    localparam int NUM_JOBS = 9;
    localparam int COLS     = 12; // Values per line of the golden file
    localparam int LANES    = `SOFTEX_NUM_LANES;

    logic             clk_i;
    logic             rst_ni;
    logic             reg_req_i;
    logic [2:0]       reg_addr_i;
    logic [31:0]      reg_wdata_i;
    logic             in_done_i;
    logic             out_done_i;
    logic             slot_valid_i;
    logic [LANES-1:0] lane_busy_i;
    logic [LANES-1:0] lane_acc_done_i;
    logic [LANES-1:0] lane_inv_done_i;
    logic             done_evt_o;
    logic             busy_o;
    logic [31:0]      in_addr_o;
    logic [31:0]      out_addr_o;
    logic [31:0]      beats_o;
    logic [15:0]      slot_addr_o;
    logic             in_start_o;
    logic             out_start_o;
    logic             acc_finished_o;
    logic             dividing_o;
    logic             disable_max_o;
    logic             clear_regs_o;
    logic             load_max_o;
    logic             load_denom_o;
    logic             load_recip_o;
    logic             slot_update_o;
    logic             slot_free_o;

    logic [31:0] golden [NUM_JOBS*COLS];
    logic        dividing_q;
    logic        disable_max_q;
    // Strobe counts per job: in, out, in+out pair, update, free, max, denom, recip, clear
    int          cnt [9];

    softex_ctrl_top i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic int unsigned rand_cycles();
        return 1 + ($urandom % 6);
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %0t ns, %s is %0h, expected %0h", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
        reg_req_i   <= 1'b1;
        reg_addr_i  <= addr;
        reg_wdata_i <= data;
        @(posedge clk_i);
        reg_req_i   <= 1'b0;
    endtask

    task automatic wait_clear();
        do @(posedge clk_i); while (!clear_regs_o);
    endtask

    always @(posedge clk_i) begin
        dividing_q    <= dividing_o;
        disable_max_q <= disable_max_o;
        if (rst_ni) begin
            if (in_start_o && !slot_valid_i) begin
                check("in_start_o before slot_valid_i", 32'd1, 32'd0);
            end
            cnt[0] += int'(in_start_o);
            cnt[1] += int'(out_start_o);
            cnt[2] += int'(in_start_o & out_start_o);
            cnt[3] += int'(slot_update_o);
            cnt[4] += int'(slot_free_o);
            cnt[5] += int'(load_max_o);
            cnt[6] += int'(load_denom_o);
            cnt[7] += int'(load_recip_o);
            cnt[8] += int'(clear_regs_o);
        end
    end

    // Input streamer for the accumulation pass, lanes drain one by one after it
    always @(posedge clk_i) begin
        if (in_start_o && !out_start_o) begin
            lane_busy_i <= '1;
            repeat (rand_cycles()) @(posedge clk_i);
            in_done_i <= 1'b1;
            @(posedge clk_i);
            in_done_i <= 1'b0;
            for (int l = 0; l < LANES; l++) begin
                repeat (rand_cycles()) @(posedge clk_i);
                lane_busy_i[l] <= 1'b0;
            end
        end
    end

    always @(posedge clk_i) begin
        if (acc_finished_o) begin
            for (int l = 0; l < LANES; l++) begin
                repeat (rand_cycles()) @(posedge clk_i);
                lane_acc_done_i[l] <= 1'b1;
            end
            wait_clear();
            lane_acc_done_i <= '0;
        end
    end

    // Inversion only follows accumulation, a divide-only job skips it
    always @(posedge clk_i) begin
        if (dividing_o && !dividing_q && disable_max_q) begin
            for (int l = 0; l < LANES; l++) begin
                repeat (rand_cycles()) @(posedge clk_i);
                lane_inv_done_i[l] <= 1'b1;
            end
            wait_clear();
            lane_inv_done_i <= '0;
        end
    end

    always @(posedge clk_i) begin
        if (out_start_o) begin
            repeat (rand_cycles()) @(posedge clk_i);
            out_done_i <= 1'b1; // Held until the job ends
            wait_clear();
            out_done_i <= 1'b0;
        end
    end

    task automatic run_job(input int j);
        logic [31:0] cmd;
        logic [31:0] dly;
        logic [31:0] spoil;
        logic        loads_on;
        int          base;
        base     = j * COLS;
        cmd      = golden[base];
        dly      = golden[base+4];
        spoil    = golden[base+5];
        loads_on = (cmd[`SOFTEX_CMD_ACC_ONLY] | cmd[`SOFTEX_CMD_DIV_ONLY])
                   & ~cmd[`SOFTEX_CMD_ACQUIRE_SLOT] & ~cmd[`SOFTEX_CMD_NO_OP];

        @(posedge clk_i);
        slot_valid_i <= (dly == 0);
        write_reg(`SOFTEX_REG_COMMANDS, cmd);
        if (golden[base+6] != 0) begin
            write_reg(`SOFTEX_REG_TOT_LEN, golden[base+1]);
        end
        write_reg(`SOFTEX_REG_IN_ADDR, golden[base+2]);
        write_reg(`SOFTEX_REG_OUT_ADDR, golden[base+3]);
        foreach (cnt[k]) cnt[k] = 0;
        write_reg(`SOFTEX_REG_TRIGGER, 32'd0);
        if (dly != 0) begin
            repeat (dly) @(posedge clk_i);
            slot_valid_i <= 1'b1;
        end
        if (spoil != 0) begin
            while (!busy_o) @(posedge clk_i);
            write_reg(`SOFTEX_REG_TOT_LEN, spoil); // Must be dropped by the bank
        end
        do @(posedge clk_i); while (!done_evt_o);

        check("beats_o", beats_o, golden[base+7]);
        check("in_addr_o", in_addr_o, golden[base+2]);
        check("out_addr_o", out_addr_o, golden[base+3]);
        check("slot_addr_o", {16'd0, slot_addr_o}, {16'd0, cmd[31:16]});
        check("in_start_o count", cnt[0], golden[base+8]);
        check("out_start_o count", cnt[1], golden[base+9]);
        check("in and out start pair count", cnt[2], golden[base+9]);
        check("slot_update_o count", cnt[3], golden[base+10]);
        check("slot_free_o count", cnt[4], golden[base+11]);
        check("load_max_o count", cnt[5], 32'(loads_on));
        check("load_denom_o count", cnt[6], 32'(loads_on & cmd[`SOFTEX_CMD_ACC_ONLY]));
        check("load_recip_o count", cnt[7], 32'(loads_on & cmd[`SOFTEX_CMD_DIV_ONLY]));
        check("clear_regs_o count", cnt[8], 32'd1);
        slot_valid_i <= 1'b0;
    endtask

    initial begin
        void'($urandom(48));
        rst_ni          = 1'b0;
        reg_req_i       = 1'b0;
        reg_addr_i      = '0;
        reg_wdata_i     = '0;
        in_done_i       = 1'b0;
        out_done_i      = 1'b0;
        slot_valid_i    = 1'b0;
        lane_busy_i     = '0;
        lane_acc_done_i = '0;
        lane_inv_done_i = '0;
        $readmemh("testbench/softex_ctrl_golden.txt", golden);
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;
        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(j);
        end
        repeat (4) @(posedge clk_i);
        if (i_dut.i_props.failures == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("error: %0t ns, %0d assertion failures", $time, i_dut.i_props.failures);
            $display("Checks failed");
            $fatal(1);
        end
    end

    initial begin
        #(NUM_JOBS * 2000);
        $display("Timeout, the DUT did not complete all jobs in time");
        $display("Checks failed");
        $fatal(1);
    end

endmodule

`default_nettype wire
